//--- compile.f
+incdir+.
x300_radio_pkg.sv
tag_chip_modulator.sv
fe_tx_control.sv
db_control.sv
x300_radio_core.sv
tb_x300_radio_core.sv

//--- db_control.sv
// one daughterboard's registers, strobe must already be qualified by board select
`timescale 1ns/1ps
`default_nettype none

`include "x300_radio_params.svh"

module db_control (
   input  wire                             radio_clk,
   input  wire                             i_reset,
   // settings
   input  wire                             i_set_stb,
   input  wire x300_radio_pkg::set_addr_t  i_set_addr,
   input  wire x300_radio_pkg::word_t      i_set_data,
   // readback
   input  wire                             i_rb_stb,
   input  wire x300_radio_pkg::set_addr_t  i_rb_addr,
   output x300_radio_pkg::rb_data_t        o_rb_data,
   // status sources
   input  wire x300_radio_pkg::word_t      i_misc_in,
   input  wire x300_radio_pkg::word_t      i_db_gpio_in,
   input  wire                             i_pps_parity,
   input  wire                             i_sync_sel,
   // board outputs
   output x300_radio_pkg::word_t           o_misc_out,
   output x300_radio_pkg::led_t            o_leds,
   output x300_radio_pkg::word_t           o_db_gpio_out,
   output x300_radio_pkg::word_t           o_db_gpio_ddr
);
   import x300_radio_pkg::*;

   rb_data_t rb_mux;

   // ------------------------------------------------------------
   // settings registers
   // ------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_misc_out    <= '0;
         o_leds        <= '0;
         o_db_gpio_out <= '0;
         o_db_gpio_ddr <= '0;   // all pins start as inputs
      end else if (i_set_stb) begin
         case (i_set_addr)
            `SR_MISC_OUT:    o_misc_out    <= i_set_data;
            `SR_LEDS:        o_leds        <= led_t'(i_set_data);
            `SR_DB_GPIO_OUT: o_db_gpio_out <= i_set_data;
            `SR_DB_GPIO_DDR: o_db_gpio_ddr <= i_set_data;
            default: ;   // front-end addresses land in fe_tx_control
         endcase
      end
   end

   // ------------------------------------------------------------
   // readback
   // ------------------------------------------------------------
   always_comb begin
      case (i_rb_addr)
         `RB_MISC_IN:    rb_mux = rb_data_t'(i_misc_in);
         `RB_DB_GPIO_IN: rb_mux = rb_data_t'(i_db_gpio_in);
         `RB_STATUS:     rb_mux = rb_data_t'({i_sync_sel, i_pps_parity});
         `RB_MISC_OUT:   rb_mux = rb_data_t'(o_misc_out);
         `RB_LEDS:       rb_mux = rb_data_t'(o_leds);
         default:        rb_mux = '0;   // unmapped reads as zero
      endcase
   end

   // held until the next read
   always_ff @(posedge radio_clk) begin
      if (i_rb_stb) o_rb_data <= rb_mux;
   end

   // the host never reads and writes in one cycle
   a_set_rb_exclusive: assert property (
      @(posedge radio_clk) disable iff (i_reset)
      !(i_set_stb && i_rb_stb)
   );

endmodule

`default_nettype wire

//--- fe_tx_control.sv
// transmit front end, one register stage of latency, dc offsets wrap at 16 bits
`timescale 1ns/1ps
`default_nettype none

`include "x300_radio_params.svh"

module fe_tx_control (
   input  wire                             radio_clk,
   input  wire                             i_reset,
   input  wire                             i_set_stb,
   input  wire x300_radio_pkg::set_addr_t  i_set_addr,
   input  wire x300_radio_pkg::word_t      i_set_data,
   input  wire x300_radio_pkg::iq_sample_t i_tx_sample,
   output x300_radio_pkg::iq_sample_t      o_tx_sample
);
   import x300_radio_pkg::*;

   logic     swap_iq;
   iq_comp_t dc_i;
   iq_comp_t dc_q;
   iq_comp_t in_i;
   iq_comp_t in_q;
   iq_comp_t sum_i;
   iq_comp_t sum_q;

   // ------------------------------------------------------------
   // front-end settings
   // ------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         swap_iq <= 1'b0;
         dc_i    <= '0;
         dc_q    <= '0;
      end else if (i_set_stb) begin
         case (i_set_addr)
            `SR_TX_FE_SWAP: swap_iq <= i_set_data[0];
            `SR_TX_FE_DC:   {dc_i, dc_q} <= i_set_data;
            default: ;
         endcase
      end
   end

   // swap first, then offset
   assign {in_i, in_q} = swap_iq ?
      {i_tx_sample[`IQ_COMP_WIDTH-1:0], i_tx_sample[2*`IQ_COMP_WIDTH-1:`IQ_COMP_WIDTH]} :
      i_tx_sample;

   assign sum_i = in_i + dc_i;   // wraps, no saturation
   assign sum_q = in_q + dc_q;

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_tx_sample <= '0;
      end else begin
         o_tx_sample <= {sum_i, sum_q};
      end
   end

   // settings and upstream sample must both be clean once out of reset
   a_tx_known: assert property (
      @(posedge radio_clk) disable iff (i_reset)
      !$isunknown(o_tx_sample)
   );

endmodule

`default_nettype wire

//--- tag_chip_modulator.sv
// free-running qpsk chip source, starts one cycle after reset and cannot be paused
`timescale 1ns/1ps
`default_nettype none

`include "x300_radio_params.svh"

module tag_chip_modulator (
   input  wire                        radio_clk,
   input  wire                        i_reset,
   output x300_radio_pkg::iq_sample_t o_sample,
   output logic                       o_sync_sel,
   output x300_radio_pkg::fp_gpio_t   o_fp_gpio_out,
   output x300_radio_pkg::fp_gpio_t   o_fp_gpio_ddr
);
   import x300_radio_pkg::*;

   localparam int       SAMP_W  = $clog2(`TAG_SAMPLES_PER_CHIP);
   localparam int       CHIP_W  = $clog2(`TAG_NSYMB);
   localparam int       COMP_W  = `IQ_COMP_WIDTH;
   localparam iq_comp_t AMP_POS = iq_comp_t'(`TAG_CHIP_AMP);
   localparam iq_comp_t AMP_NEG = iq_comp_t'(-`TAG_CHIP_AMP);

   tag_state_t        state;
   logic [15:0]       lfsr;
   logic              lfsr_fb;
   logic [SAMP_W-1:0] samp_cnt;   // sample within chip
   logic [CHIP_W-1:0] chip_cnt;   // chip within frame
   logic              sync_sel;
   logic              chip_end;
   logic              frame_end;
   logic              marker;
   iq_comp_t          chip_i;
   iq_comp_t          chip_q;

   // fibonacci taps 16,14,13,11 shifting right
   assign lfsr_fb   = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];
   assign chip_end  = (samp_cnt == SAMP_W'(`TAG_SAMPLES_PER_CHIP - 1));
   assign frame_end = chip_end && (chip_cnt == CHIP_W'(`TAG_NSYMB - 1));
   assign marker    = (samp_cnt == '0) && (chip_cnt == '0);

   assign chip_i = lfsr[0] ? AMP_NEG : AMP_POS;
   assign chip_q = lfsr[1] ? AMP_NEG : AMP_POS;

   // ------------------------------------------------------------
   // chip and frame sequencing
   // ------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         state    <= TAG_IDLE;
         lfsr     <= `TAG_LFSR_SEED;
         samp_cnt <= '0;
         chip_cnt <= '0;
         sync_sel <= 1'b0;
      end else begin
         case (state)
            TAG_IDLE: state <= TAG_RUN;
            TAG_RUN: begin
               samp_cnt <= samp_cnt + 1'b1;
               if (chip_end) begin
                  samp_cnt <= '0;
                  chip_cnt <= chip_cnt + 1'b1;
                  lfsr     <= {lfsr_fb, lfsr[15:1]};
               end
               if (frame_end) begin   // new frame restarts the sequence
                  chip_cnt <= '0;
                  lfsr     <= `TAG_LFSR_SEED;
                  sync_sel <= ~sync_sel;
               end
            end
            default: state <= TAG_IDLE;
         endcase
      end
   end

   // ------------------------------------------------------------
   // output register, sample and pins leave together
   // ------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_sample      <= '0;
         o_sync_sel    <= 1'b0;
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
      end else if (state == TAG_RUN) begin
         o_sample      <= {chip_i, chip_q};
         o_sync_sel    <= sync_sel;
         o_fp_gpio_out <= fp_gpio_t'({sync_sel, marker});   // pin1 sync, pin0 frame start
         o_fp_gpio_ddr <= '1;
      end
   end

   // once the pins turn to outputs every component sits at full amplitude
   a_chip_amp: assert property (
      @(posedge radio_clk) disable iff (i_reset)
      o_fp_gpio_ddr[0] |->
         (o_sample[2*COMP_W-1:COMP_W] == AMP_POS || o_sample[2*COMP_W-1:COMP_W] == AMP_NEG) &&
         (o_sample[COMP_W-1:0] == AMP_POS || o_sample[COMP_W-1:0] == AMP_NEG)
   );

endmodule

`default_nettype wire

//--- tb_x300_radio_core.sv
// expects the project root as working directory for x300_radio_stimulus.txt and checks two frames on a T line
`timescale 1ns/1ps
`default_nettype none

`include "x300_radio_params.svh"

module tb_x300_radio_core;
   import x300_radio_pkg::*;

   localparam int CLK_HALF     = 20;   // 40 ns period
   localparam int RESET_CYCLES = 5;
   localparam int PPS_HOLD     = 4;
   localparam int FRAME_CYCLES = `TAG_NSYMB * `TAG_SAMPLES_PER_CHIP;
   localparam logic [15:0] LFSR_TAPS = 16'h002d;   // taps 16,14,13,11 as bits 0,2,3,5

   logic       radio_clk;
   logic       i_reset;
   logic       i_set_stb;
   logic       i_set_dboard;
   set_addr_t  i_set_addr;
   word_t      i_set_data;
   logic       i_rb_stb;
   logic       i_rb_dboard;
   set_addr_t  i_rb_addr;
   word_t      i_misc_in0;
   word_t      i_misc_in1;
   word_t      i_db0_gpio_in;
   word_t      i_db1_gpio_in;
   logic       i_pps;
   logic       o_rb_valid;
   rb_data_t   o_rb_data;
   iq_sample_t o_tx0;
   iq_sample_t o_tx1;
   fp_gpio_t   o_fp_gpio_out;
   fp_gpio_t   o_fp_gpio_ddr;
   word_t      o_db0_gpio_out;
   word_t      o_db0_gpio_ddr;
   word_t      o_db1_gpio_out;
   word_t      o_db1_gpio_ddr;
   word_t      o_misc_out0;
   word_t      o_misc_out1;
   led_t       o_radio_led0;
   led_t       o_radio_led1;

   integer     seed = 32'h05bfbf5e;
   logic [7:0] ops [$];    // one opcode per stimulus line
   word_t      args [$];   // four fields per line with unused ones zero
   word_t      exp_misc_out [2];
   word_t      exp_gpio_out [2];
   word_t      exp_gpio_ddr [2];
   led_t       exp_leds [2];
   logic       fe_swap [2];
   word_t      fe_dc [2];
   int         pps_count;
   int         run_cycles;   // rising edges since reset release

   x300_radio_core i_dut (.*);

   always #CLK_HALF radio_clk = ~radio_clk;

   always @(posedge radio_clk) begin
      if (i_reset) begin
         run_cycles <= 0;
      end else begin
         run_cycles <= run_cycles + 1;
      end
   end

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [63:0] exp_val,
                              input logic [63:0] act_val);
      assert (act_val === exp_val) else
         report_failure($sformatf("mismatch %s expected %h actual %h", name, exp_val, act_val));
   endtask

   // ------------------------------------------------------------
   // reference models
   // ------------------------------------------------------------
   function automatic logic [15:0] lfsr_next(input logic [15:0] lfsr);
      return {^(lfsr & LFSR_TAPS), lfsr[15:1]};
   endfunction

   function automatic iq_sample_t chip_model(input logic [15:0] lfsr);
      logic [15:0] amp;
      amp = `TAG_CHIP_AMP;
      return {lfsr[0] ? 16'd0 - amp : amp, lfsr[1] ? 16'd0 - amp : amp};
   endfunction

   function automatic iq_sample_t fe_model(input iq_sample_t s, input logic swap, input word_t dc);
      logic [15:0] i_c;
      logic [15:0] q_c;
      i_c = (swap ? s[15:0] : s[31:16]) + dc[31:16];   // 16-bit wrap
      q_c = (swap ? s[31:16] : s[15:0]) + dc[15:0];
      return {i_c, q_c};
   endfunction

   function automatic int field_count(input logic [7:0] op);
      case (op)
         "W", "R": return 3;
         "M":      return 4;
         "P":      return 1;
         "T":      return 2;
         default:  return 0;
      endcase
   endfunction

   task automatic read_stimulus();
      int               fd;
      int               code;
      logic [7:0]       op;
      word_t            val;
      logic [8*128-1:0] rest;
      fd = $fopen("x300_radio_stimulus.txt", "r");
      assert (fd != 0) else report_failure("cannot open x300_radio_stimulus.txt");
      code = $fscanf(fd, " %c", op);
      while (code == 1) begin
         if (op == "#") begin
            code = $fgets(rest, fd);   // comment line
         end else begin
            ops.push_back(op);
            for (int j = 0; j < 4; j++) begin
               val = '0;
               if (j < field_count(op)) begin
                  code = $fscanf(fd, " %h", val);
                  assert (code == 1) else report_failure("malformed line in stimulus file");
               end
               args.push_back(val);
            end
         end
         code = $fscanf(fd, " %c", op);
      end
      $fclose(fd);
   endtask

   // ------------------------------------------------------------
   // bus tasks start and end on a falling edge
   // ------------------------------------------------------------
   task automatic check_board_outputs(input string when);
      check_value({when, " misc_out0"}, exp_misc_out[0], o_misc_out0);
      check_value({when, " misc_out1"}, exp_misc_out[1], o_misc_out1);
      check_value({when, " led0"}, exp_leds[0], o_radio_led0);
      check_value({when, " led1"}, exp_leds[1], o_radio_led1);
      check_value({when, " db0_gpio_out"}, exp_gpio_out[0], o_db0_gpio_out);
      check_value({when, " db0_gpio_ddr"}, exp_gpio_ddr[0], o_db0_gpio_ddr);
      check_value({when, " db1_gpio_out"}, exp_gpio_out[1], o_db1_gpio_out);
      check_value({when, " db1_gpio_ddr"}, exp_gpio_ddr[1], o_db1_gpio_ddr);
   endtask

   task automatic write_reg(input logic b, input set_addr_t addr, input word_t data);
      i_set_stb    = 1'b1;
      i_set_dboard = b;
      i_set_addr   = addr;
      i_set_data   = data;
      @(negedge radio_clk);
      i_set_stb = 1'b0;
      case (addr)
         `SR_MISC_OUT:    exp_misc_out[b] = data;
         `SR_LEDS:        exp_leds[b] = data[2:0];
         `SR_DB_GPIO_OUT: exp_gpio_out[b] = data;
         `SR_DB_GPIO_DDR: exp_gpio_ddr[b] = data;
         `SR_TX_FE_SWAP:  fe_swap[b] = data[0];
         `SR_TX_FE_DC:    fe_dc[b] = data;
         default: ;
      endcase
      @(negedge radio_clk);   // misc out has one extra register
      check_board_outputs($sformatf("write board %0d addr %h", b, addr));
   endtask

   task automatic read_reg(input logic b, input set_addr_t addr, output rb_data_t data);
      assert (o_rb_valid === 1'b0) else report_failure("o_rb_valid was high with no read");
      i_rb_stb    = 1'b1;
      i_rb_dboard = b;
      i_rb_addr   = addr;
      @(negedge radio_clk);
      i_rb_stb = 1'b0;
      assert (o_rb_valid === 1'b1) else
         report_failure("o_rb_valid did not pulse one cycle after i_rb_stb");
      data = o_rb_data;
      @(negedge radio_clk);
      assert (o_rb_valid === 1'b0) else report_failure("o_rb_valid stayed high for two cycles");
   endtask

   task automatic pulse_pps(input int n);
      rb_data_t status;
      repeat (n) begin
         i_pps = 1'b1;
         repeat (PPS_HOLD) @(negedge radio_clk);
         i_pps = 1'b0;
         repeat (PPS_HOLD) @(negedge radio_clk);
      end
      pps_count += n;
      for (int b = 0; b < 2; b++) begin
         read_reg(b[0], `RB_STATUS, status);
         check_value($sformatf("pps parity board %0d", b), pps_count % 2, status[0]);
      end
   endtask

   // two whole frames from the next marker of an even frame since reset
   task automatic check_frames();
      logic [15:0] lfsr;
      logic        sync;
      iq_sample_t  chip;
      string       tag;
      int          wait_cnt;
      wait_cnt = 0;
      while (o_fp_gpio_out[0] !== 1'b1 || (run_cycles / FRAME_CYCLES) % 2 != 0) begin
         assert (wait_cnt < 2 * FRAME_CYCLES) else
            report_failure("no frame marker seen on o_fp_gpio_out[0]");
         wait_cnt++;
         @(negedge radio_clk);
      end
      sync = 1'b0;   // sync_sel starts low after reset
      for (int f = 0; f < 2; f++) begin
         lfsr = `TAG_LFSR_SEED;
         for (int c = 0; c < `TAG_NSYMB; c++) begin
            chip = chip_model(lfsr);
            for (int s = 0; s < `TAG_SAMPLES_PER_CHIP; s++) begin
               tag = $sformatf("frame %0d chip %0d sample %0d", f, c, s);
               check_value($sformatf("marker %s", tag), c == 0 && s == 0, o_fp_gpio_out[0]);
               check_value($sformatf("sync pin %s", tag), sync, o_fp_gpio_out[1]);
               check_value($sformatf("fp ddr %s", tag), 12'hfff, o_fp_gpio_ddr);
               check_value($sformatf("tx0 %s", tag), fe_model(chip, fe_swap[0], fe_dc[0]), o_tx0);
               // radio 1 input is zero while pin1 is high
               check_value($sformatf("tx1 %s", tag),
                           fe_model(sync ? '0 : chip, fe_swap[1], fe_dc[1]), o_tx1);
               @(negedge radio_clk);
            end
            lfsr = lfsr_next(lfsr);
         end
         sync = ~sync;   // flips every frame
      end
      check_value("marker after two frames", 1, o_fp_gpio_out[0]);
   endtask

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial begin
      rb_data_t data;
      radio_clk     = 1'b0;
      i_reset       = 1'b1;
      i_set_stb     = 1'b0;
      i_set_dboard  = 1'b0;
      i_set_addr    = '0;
      i_set_data    = '0;
      i_rb_stb      = 1'b0;
      i_rb_dboard   = 1'b0;
      i_rb_addr     = '0;
      i_misc_in0    = $random(seed);   // filler until an M line
      i_misc_in1    = $random(seed);
      i_db0_gpio_in = '0;
      i_db1_gpio_in = '0;
      i_pps         = 1'b0;
      pps_count     = 0;
      for (int b = 0; b < 2; b++) begin
         exp_misc_out[b] = '0;
         exp_gpio_out[b] = '0;
         exp_gpio_ddr[b] = '0;
         exp_leds[b]     = '0;
         fe_swap[b]      = 1'b0;
         fe_dc[b]        = '0;
      end
      read_stimulus();
      repeat (RESET_CYCLES) @(posedge radio_clk);
      @(negedge radio_clk);
      i_reset = 1'b0;
      @(negedge radio_clk);
      check_value("rb_valid after reset", 0, o_rb_valid);
      check_value("tx0 after reset", 0, o_tx0);
      check_value("tx1 after reset", 0, o_tx1);
      check_value("fp ddr after reset", 0, o_fp_gpio_ddr);
      check_board_outputs("after reset");
      for (int k = 0; k < ops.size(); k++) begin
         case (ops[k])
            "W": write_reg(args[4*k][0], args[4*k+1][7:0], args[4*k+2]);
            "R": begin
               read_reg(args[4*k][0], args[4*k+1][7:0], data);
               check_value($sformatf("line %0d read board %0d addr %h", k + 1,
                                     args[4*k][0], args[4*k+1][7:0]), args[4*k+2], data);
            end
            "M": begin
               i_misc_in0    = args[4*k];
               i_misc_in1    = args[4*k+1];
               i_db0_gpio_in = args[4*k+2];
               i_db1_gpio_in = args[4*k+3];
               @(negedge radio_clk);
            end
            "P": pulse_pps(args[4*k]);
            "T": begin
               write_reg(1'b1, `SR_TX_FE_SWAP, args[4*k]);
               write_reg(1'b1, `SR_TX_FE_DC, args[4*k+1]);
               check_frames();
            end
            default: report_failure($sformatf("unknown opcode on stimulus line %0d", k + 1));
         endcase
      end
      $display("TESTBENCH PASSED");
      $finish;
   end

   // budget of three frames plus 200 cycles per stimulus line
   initial begin
      #1;
      repeat (RESET_CYCLES + 3 * FRAME_CYCLES + 200 * ops.size()) @(posedge radio_clk);
      report_failure("watchdog timeout, the stimulus did not finish in time");
   end

endmodule

`default_nettype wire

//--- x300_radio_core.sv
// radio clock domain only, one settings/readback bus shared by both boards, no back-pressure
`timescale 1ns/1ps
`default_nettype none

`include "x300_radio_params.svh"

module x300_radio_core (
   input  wire                             radio_clk,
   input  wire                             i_reset,
   // settings bus
   input  wire                             i_set_stb,
   input  wire                             i_set_dboard,
   input  wire x300_radio_pkg::set_addr_t  i_set_addr,
   input  wire x300_radio_pkg::word_t      i_set_data,
   // readback bus
   input  wire                             i_rb_stb,
   input  wire                             i_rb_dboard,
   input  wire x300_radio_pkg::set_addr_t  i_rb_addr,
   output logic                            o_rb_valid,
   output x300_radio_pkg::rb_data_t        o_rb_data,
   // misc and gpio
   input  wire x300_radio_pkg::word_t      i_misc_in0,
   input  wire x300_radio_pkg::word_t      i_misc_in1,
   input  wire x300_radio_pkg::word_t      i_db0_gpio_in,
   input  wire x300_radio_pkg::word_t      i_db1_gpio_in,
   input  wire                             i_pps,
   // transmit samples
   output x300_radio_pkg::iq_sample_t      o_tx0,
   output x300_radio_pkg::iq_sample_t      o_tx1,
   output x300_radio_pkg::fp_gpio_t        o_fp_gpio_out,
   output x300_radio_pkg::fp_gpio_t        o_fp_gpio_ddr,
   output x300_radio_pkg::word_t           o_db0_gpio_out,
   output x300_radio_pkg::word_t           o_db0_gpio_ddr,
   output x300_radio_pkg::word_t           o_db1_gpio_out,
   output x300_radio_pkg::word_t           o_db1_gpio_ddr,
   output x300_radio_pkg::word_t           o_misc_out0,
   output x300_radio_pkg::word_t           o_misc_out1,
   output x300_radio_pkg::led_t            o_radio_led0,
   output x300_radio_pkg::led_t            o_radio_led1
);
   import x300_radio_pkg::*;

   word_t      misc_in_q   [`NUM_DBOARDS];
   word_t      misc_out_db [`NUM_DBOARDS];
   word_t      db_gpio_in  [`NUM_DBOARDS];
   word_t      db_gpio_out [`NUM_DBOARDS];
   word_t      db_gpio_ddr [`NUM_DBOARDS];
   led_t       leds        [`NUM_DBOARDS];
   rb_data_t   rb_data     [`NUM_DBOARDS];
   iq_sample_t tx_in       [`NUM_DBOARDS];
   iq_sample_t tx_out      [`NUM_DBOARDS];
   logic       set_stb     [`NUM_DBOARDS];
   logic       rb_stb      [`NUM_DBOARDS];

   logic       pps_meta;
   logic       pps_sync;
   logic       pps_prev;
   logic       pps_parity;
   logic       rb_sel;
   iq_sample_t chip_sample;
   logic       sync_sel;
   fp_gpio_t   mod_gpio_out;
   fp_gpio_t   mod_gpio_ddr;

   // ------------------------------------------------------------
   // pps into radio_clk, parity flips 3 cycles after a rising edge
   // ------------------------------------------------------------
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         pps_meta   <= 1'b0;
         pps_sync   <= 1'b0;
         pps_prev   <= 1'b0;
         pps_parity <= 1'b0;
      end else begin
         pps_meta <= i_pps;
         pps_sync <= pps_meta;
         pps_prev <= pps_sync;
         if (pps_sync && !pps_prev) pps_parity <= ~pps_parity;   // rising edge
      end
   end

   // misc words, one register each way
   always_ff @(posedge radio_clk) begin
      misc_in_q[0] <= i_misc_in0;
      misc_in_q[1] <= i_misc_in1;
   end

   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_misc_out0 <= '0;
         o_misc_out1 <= '0;
      end else begin
         o_misc_out0 <= misc_out_db[0];
         o_misc_out1 <= misc_out_db[1];
      end
   end

   // readback answers one cycle after the strobe
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_rb_valid <= 1'b0;
         rb_sel     <= 1'b0;
      end else begin
         o_rb_valid <= i_rb_stb;
         if (i_rb_stb) rb_sel <= i_rb_dboard;
      end
   end

   assign o_rb_data = rb_data[rb_sel];

   // ------------------------------------------------------------
   // modulator, the only transmit source
   // ------------------------------------------------------------
   tag_chip_modulator u_tag_chip_modulator (
      .radio_clk     (radio_clk),
      .i_reset       (i_reset),
      .o_sample      (chip_sample),
      .o_sync_sel    (sync_sel),
      .o_fp_gpio_out (mod_gpio_out),
      .o_fp_gpio_ddr (mod_gpio_ddr)
   );

   assign tx_in[0] = chip_sample;
   assign tx_in[1] = sync_sel ? '0 : chip_sample;   // radio 1 silent on sync frames

   // matches the front-end register so pins line up with o_tx
   always_ff @(posedge radio_clk) begin
      if (i_reset) begin
         o_fp_gpio_out <= '0;
         o_fp_gpio_ddr <= '0;
      end else begin
         o_fp_gpio_out <= mod_gpio_out;
         o_fp_gpio_ddr <= mod_gpio_ddr;
      end
   end

   // ------------------------------------------------------------
   // per-daughterboard control and front end
   // ------------------------------------------------------------
   for (genvar g = 0; g < `NUM_DBOARDS; g++) begin : gen_radio
      assign set_stb[g] = i_set_stb && (i_set_dboard == 1'(g));
      assign rb_stb[g]  = i_rb_stb && (i_rb_dboard == 1'(g));

      db_control u_db_control (
         .radio_clk     (radio_clk),
         .i_reset       (i_reset),
         .i_set_stb     (set_stb[g]),
         .i_set_addr    (i_set_addr),
         .i_set_data    (i_set_data),
         .i_rb_stb      (rb_stb[g]),
         .i_rb_addr     (i_rb_addr),
         .o_rb_data     (rb_data[g]),
         .i_misc_in     (misc_in_q[g]),
         .i_db_gpio_in  (db_gpio_in[g]),
         .i_pps_parity  (pps_parity),
         .i_sync_sel    (sync_sel),
         .o_misc_out    (misc_out_db[g]),
         .o_leds        (leds[g]),
         .o_db_gpio_out (db_gpio_out[g]),
         .o_db_gpio_ddr (db_gpio_ddr[g])
      );

      fe_tx_control u_fe_tx_control (
         .radio_clk   (radio_clk),
         .i_reset     (i_reset),
         .i_set_stb   (set_stb[g]),   // same strobe as db_control
         .i_set_addr  (i_set_addr),
         .i_set_data  (i_set_data),
         .i_tx_sample (tx_in[g]),
         .o_tx_sample (tx_out[g])
      );
   end

   assign db_gpio_in[0]  = i_db0_gpio_in;
   assign db_gpio_in[1]  = i_db1_gpio_in;
   assign o_db0_gpio_out = db_gpio_out[0];
   assign o_db0_gpio_ddr = db_gpio_ddr[0];
   assign o_db1_gpio_out = db_gpio_out[1];
   assign o_db1_gpio_ddr = db_gpio_ddr[1];
   assign o_radio_led0   = leds[0];
   assign o_radio_led1   = leds[1];
   assign o_tx0          = tx_out[0];
   assign o_tx1          = tx_out[1];

endmodule

`default_nettype wire

//--- x300_radio_params.svh
// widths and register map for the radio core, addresses are 8-bit bus offsets
`ifndef X300_RADIO_PARAMS_SVH
`define X300_RADIO_PARAMS_SVH

// bus and sample widths
`define WORD_WIDTH           32
`define SET_ADDR_WIDTH       8
`define RB_DATA_WIDTH        64
`define IQ_COMP_WIDTH        16
`define LED_WIDTH            3
`define FP_GPIO_WIDTH        12
`define NUM_DBOARDS          2

// settings registers, one copy per daughterboard
`define SR_DB_BASE           8'd160
`define SR_MISC_OUT          (`SR_DB_BASE + 8'd0)
`define SR_LEDS              (`SR_DB_BASE + 8'd1)
`define SR_DB_GPIO_OUT       (`SR_DB_BASE + 8'd2)
`define SR_DB_GPIO_DDR       (`SR_DB_BASE + 8'd3)
`define SR_TX_FE_BASE        (`SR_DB_BASE + 8'd48)
`define SR_TX_FE_SWAP        (`SR_TX_FE_BASE + 8'd0)  // bit0 swaps i and q
`define SR_TX_FE_DC          (`SR_TX_FE_BASE + 8'd1)  // i offset high, q offset low

// readback words
`define RB_DB_BASE           8'd16
`define RB_MISC_IN           (`RB_DB_BASE + 8'd0)
`define RB_DB_GPIO_IN        (`RB_DB_BASE + 8'd1)
`define RB_STATUS            (`RB_DB_BASE + 8'd2)     // bit0 pps parity, bit1 sync_sel
`define RB_MISC_OUT          (`RB_DB_BASE + 8'd3)
`define RB_LEDS              (`RB_DB_BASE + 8'd4)

// tag chip modulator
`define TAG_NSYMB            512
`define TAG_SAMPLES_PER_CHIP 4
`define TAG_CHIP_AMP         8192
`define TAG_LFSR_SEED        16'hACE1

`endif

//--- x300_radio_pkg.sv
// shared types for the radio core, the params header must be compiled ahead of this package
`default_nettype none

`include "x300_radio_params.svh"

package x300_radio_pkg;

   // ------------------------------------------------------------
   // bus words
   // ------------------------------------------------------------
   typedef logic [`WORD_WIDTH-1:0]     word_t;       // settings data, gpio, misc
   typedef logic [`SET_ADDR_WIDTH-1:0] set_addr_t;   // settings and readback address
   typedef logic [`RB_DATA_WIDTH-1:0]  rb_data_t;

   // ------------------------------------------------------------
   // samples and pins
   // ------------------------------------------------------------

   // i in the upper half, q in the lower half
   typedef logic [2*`IQ_COMP_WIDTH-1:0]      iq_sample_t;
   typedef logic signed [`IQ_COMP_WIDTH-1:0] iq_comp_t;

   typedef logic [`FP_GPIO_WIDTH-1:0] fp_gpio_t;
   typedef logic [`LED_WIDTH-1:0]     led_t;        // {rx, txrx_tx, txrx_rx}

   // modulator control
   typedef enum logic {
      TAG_IDLE,   // held here through reset
      TAG_RUN     // free running chips and frames
   } tag_state_t;

endpackage

`default_nettype wire

//--- x300_radio_stimulus.txt
# W board addr data | R board addr expected | M misc_in0 misc_in1 db0_gpio_in db1_gpio_in
# P pps_pulse_count | T radio1_swap radio1_dc(i high, q low), all fields hex
W 0 a0 deadbeef
W 1 a0 13572468
R 0 13 deadbeef
R 1 13 13572468
W 0 a1 7
W 1 a1 2
R 0 14 7
R 1 14 2
W 0 a2 0000f00d
W 0 a3 0000ffff
W 1 a2 a5a50000
W 1 a3 ffff0000
M 11112222 33334444 0badc0de 600dcafe
R 0 10 11112222
R 1 10 33334444
R 0 11 0badc0de
R 1 11 600dcafe
R 0 99 0
W 1 a1 5
R 1 14 5
R 0 14 7
R 0 13 deadbeef
P 3
P 2
P 1
T 1 0100fff0
